// File: verilog/mosaic_macros.svh
// widths, burst geometry and DDR layout constants for the mosaic line reader
`ifndef MOSAIC_MACROS_SVH
`define MOSAIC_MACROS_SVH

// bus widths
`define MR_ADDR_W 28
`define MR_DATA_W 64

// one burst is MR_BURST_LEN beats of 64 bits
`define MR_BURST_LEN 4
`define MR_ADDR_STEP (`MR_BURST_LEN * 8)

// tile geometry
`define MR_LINE_BURSTS 2  // bursts per tile per display line
`define MR_TILE_ROWS 3    // lines in one tile frame
`define MR_TILE_FRAME_SPAN (`MR_LINE_BURSTS * `MR_TILE_ROWS * `MR_ADDR_STEP)

// each tile owns two banks, frames 2 and 3 use the upper one
`define MR_FRAME_OFFSET 1024
`define MR_TILE_SPACING (2 * `MR_FRAME_OFFSET)

`endif

// File: verilog/mosaic_pkg.sv
// shared types for the mosaic line reader
// tile index, DDR address, read beat and sequencer states

`include "mosaic_macros.svh"

package mosaic_pkg;

    typedef logic [1:0] tile_t;                 // one of four tiles
    typedef logic [`MR_ADDR_W-1:0] addr_t;      // DDR word address
    typedef logic [`MR_DATA_W-1:0] data_t;      // one R beat

    // burst sequencer states
    typedef enum logic [1:0] {
        idle,
        addr_wait,  // request out, waiting for AR accept
        data_wait   // burst in flight, waiting for rlast
    } seq_state_e;

endpackage

// File: verilog/burst_cmd_if.sv
// burst request handshake between sequencer, address generator and AXI reader
`timescale 1ns/1ps

interface burst_cmd_if;

    logic               req;      // sequencer wants one burst
    mosaic_pkg::tile_t  tile;     // tile the burst reads
    mosaic_pkg::addr_t  addr;     // burst start address
    logic               granted;  // AR accepted, one cycle
    logic               done;     // beat with rlast, one cycle

    modport seq (
        output req,
        output tile,
        input  granted,
        input  done
    );

    modport addr_gen (
        input  tile,
        input  granted,
        output addr
    );

    modport reader (
        input  req,
        input  addr,
        output granted,
        output done
    );

endinterface

// File: verilog/line_trigger.sv
// sync edge detection and line-read enable
`timescale 1ns/1ps

module line_trigger (
    input  logic clk,
    input  logic rst,
    input  logic init_done,
    input  logic hdmi_vsync,
    input  logic hdmi_href,
    input  logic line_done,
    output logic line_active,
    output logic frame_start
);

    logic vsync_d1;
    logic href_d1;
    logic vsync_rise;
    logic vsync_fall;
    logic href_fall;

    assign vsync_rise = hdmi_vsync & ~vsync_d1;
    assign vsync_fall = ~hdmi_vsync & vsync_d1;
    assign href_fall  = ~hdmi_href & href_d1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vsync_d1 <= 1'b0;
            href_d1  <= 1'b0;
        end else begin
            vsync_d1 <= hdmi_vsync;
            href_d1  <= hdmi_href;
        end
    end

    // a line starts on href fall, or on the vsync fall that opens the frame
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_active <= 1'b0;
        end else if ((href_fall || vsync_fall) && init_done) begin
            line_active <= 1'b1;
        end else if (line_done || vsync_rise) begin
            line_active <= 1'b0;  // new frame aborts any line in progress
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= vsync_rise;
        end
    end

endmodule

// File: verilog/tile_sequencer.sv
// walks tiles 0 to 3 per display line, MR_LINE_BURSTS bursts each
`timescale 1ns/1ps

`include "mosaic_macros.svh"

module tile_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic line_active,
    input  logic frame_start,
    burst_cmd_if.seq cmd,
    output logic line_done
);

    localparam int CNT_W = $clog2(`MR_LINE_BURSTS + 1);

    mosaic_pkg::seq_state_e state;
    mosaic_pkg::tile_t      tile;
    logic [CNT_W-1:0]       burst_cnt;
    logic                   last_burst;
    logic                   last_tile;

    assign last_burst = (burst_cnt == CNT_W'(`MR_LINE_BURSTS - 1));
    assign last_tile  = (tile == mosaic_pkg::tile_t'(3));

    assign cmd.req  = (state == mosaic_pkg::addr_wait);
    assign cmd.tile = tile;

    // final beat of the last burst of tile 3
    assign line_done = (state == mosaic_pkg::data_wait) && cmd.done && last_burst && last_tile;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= mosaic_pkg::idle;
            tile      <= '0;
            burst_cnt <= '0;
        end else if (frame_start || !line_active) begin
            state     <= mosaic_pkg::idle;
            tile      <= '0;
            burst_cnt <= '0;
        end else begin
            case (state)
                mosaic_pkg::idle: begin
                    state     <= mosaic_pkg::addr_wait;  // enter tile 0
                    tile      <= '0;
                    burst_cnt <= '0;
                end
                mosaic_pkg::addr_wait: begin
                    if (cmd.granted) begin
                        state <= mosaic_pkg::data_wait;
                    end
                end
                mosaic_pkg::data_wait: begin
                    if (cmd.done) begin
                        if (!last_burst) begin
                            burst_cnt <= burst_cnt + 1'b1;
                            state     <= mosaic_pkg::addr_wait;
                        end else if (!last_tile) begin
                            burst_cnt <= '0;
                            tile      <= tile + 1'b1;  // next tile on the same line
                            state     <= mosaic_pkg::addr_wait;
                        end else begin
                            burst_cnt <= '0;
                            state     <= mosaic_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= mosaic_pkg::idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/tile_address_gen.sv
// per-tile read offsets and frame counts, burst address composition
`timescale 1ns/1ps

`include "mosaic_macros.svh"

module tile_address_gen (
    input  logic clk,
    input  logic rst,
    input  logic frame_start,
    burst_cmd_if.addr_gen cmd
);

    localparam mosaic_pkg::addr_t STEP = mosaic_pkg::addr_t'(`MR_ADDR_STEP);
    localparam mosaic_pkg::addr_t LAST_OFFSET =
        mosaic_pkg::addr_t'(`MR_TILE_FRAME_SPAN - `MR_ADDR_STEP);

    mosaic_pkg::addr_t offset [4];     // running offset inside the tile frame
    logic [1:0]        frame_cnt [4];  // frames read per tile
    mosaic_pkg::addr_t tile_base;
    mosaic_pkg::addr_t bank_offset;
    mosaic_pkg::addr_t cur_offset;

    always_comb begin
        tile_base  = mosaic_pkg::addr_t'(cmd.tile) * mosaic_pkg::addr_t'(`MR_TILE_SPACING);
        cur_offset = offset[cmd.tile];
        // frame counts 2 and 3 sit in the second bank
        if (frame_cnt[cmd.tile][1]) begin
            bank_offset = mosaic_pkg::addr_t'(`MR_FRAME_OFFSET);
        end else begin
            bank_offset = '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 4; i++) begin
                offset[i]    <= '0;
                frame_cnt[i] <= '0;
            end
        end else if (frame_start) begin
            for (int i = 0; i < 4; i++) begin
                offset[i] <= '0;  // frame counts carry over
            end
        end else if (cmd.granted) begin
            if (cur_offset == LAST_OFFSET) begin
                offset[cmd.tile]    <= '0;
                frame_cnt[cmd.tile] <= frame_cnt[cmd.tile] + 1'b1;  // 3 wraps to 0
            end else begin
                offset[cmd.tile] <= cur_offset + STEP;
            end
        end
    end

    // follows tile and offset one cycle later
    always_ff @(posedge clk) begin
        cmd.addr <= tile_base + bank_offset + cur_offset;
    end

endmodule

// File: verilog/axi_burst_reader.sv
// AXI AR/R handling for one outstanding burst with R beats passed to the line buffer
`timescale 1ns/1ps

module axi_burst_reader (
    input  logic clk,
    input  logic rst,
    burst_cmd_if.reader cmd,
    output logic              axi_arvalid,
    input  logic              axi_arready,
    output mosaic_pkg::addr_t axi_araddr,
    output logic              axi_rready,
    input  logic              axi_rvalid,
    input  mosaic_pkg::data_t axi_rdata,
    input  logic              axi_rlast,
    output logic              buf_wr_en,
    output mosaic_pkg::data_t buf_wr_data
);

    logic beat;

    assign beat = axi_rvalid & axi_rready;

    // addr is stable from the first arvalid cycle until the grant
    assign axi_araddr = cmd.addr;

    assign cmd.granted = axi_arvalid & axi_arready;
    assign cmd.done    = beat & axi_rlast;

    assign buf_wr_en   = beat;
    assign buf_wr_data = axi_rdata;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_arvalid <= 1'b0;
            axi_rready  <= 1'b0;
        end else begin
            if (axi_arvalid) begin
                if (axi_arready) begin
                    axi_arvalid <= 1'b0;
                    axi_rready  <= 1'b1;  // burst now outstanding
                end
            end else if (cmd.req && !axi_rready) begin
                axi_arvalid <= 1'b1;
            end
            if (cmd.done) begin
                axi_rready <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/mosaic_line_reader.sv
// mosaic line reader top level reading four quarter-size tiles per display line from DDR
`timescale 1ns/1ps

`include "mosaic_macros.svh"

module mosaic_line_reader (
    input  logic              clk,
    input  logic              rst,
    input  logic              hdmi_vsync,
    input  logic              hdmi_href,
    input  logic              init_done,
    output logic              buf_wr_en,
    output mosaic_pkg::data_t buf_wr_data,
    output logic              axi_arvalid,
    input  logic              axi_arready,
    output mosaic_pkg::addr_t axi_araddr,
    output logic [3:0]        axi_arlen,
    output logic [2:0]        axi_arsize,
    output logic [1:0]        axi_arburst,
    output logic              axi_rready,
    input  mosaic_pkg::data_t axi_rdata,
    input  logic              axi_rvalid,
    input  logic              axi_rlast
);

    logic line_active;
    logic frame_start;
    logic line_done;

    burst_cmd_if cmd_if ();

    // fixed incrementing bursts of full-width beats
    assign axi_arlen   = 4'(`MR_BURST_LEN - 1);
    assign axi_arsize  = 3'($clog2(`MR_DATA_W / 8));
    assign axi_arburst = 2'b01;

    line_trigger line_trigger_i (
        .clk         (clk),
        .rst         (rst),
        .init_done   (init_done),
        .hdmi_vsync  (hdmi_vsync),
        .hdmi_href   (hdmi_href),
        .line_done   (line_done),
        .line_active (line_active),
        .frame_start (frame_start)
    );

    tile_sequencer tile_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .line_active (line_active),
        .frame_start (frame_start),
        .cmd         (cmd_if.seq),
        .line_done   (line_done)
    );

    tile_address_gen tile_address_gen_i (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .cmd         (cmd_if.addr_gen)
    );

    axi_burst_reader axi_burst_reader_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd_if.reader),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_rready  (axi_rready),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data)
    );

endmodule

// File: verification/mosaic_line_reader_tb.sv
// testbench for the mosaic line reader
// AXI read slave model, vector-driven line starts, address and data checks
`timescale 1ns/1ps

`include "mosaic_macros.svh"

module mosaic_line_reader_tb;

    localparam logic [31:0] HREF_MARK  = 32'hf000_0001;
    localparam logic [31:0] VSYNC_MARK = 32'hf000_0002;
    localparam logic [31:0] END_MARK   = 32'hf000_00ff;
    localparam int LINE_BURSTS  = 4 * `MR_LINE_BURSTS;
    localparam int LINE_WRITES  = LINE_BURSTS * `MR_BURST_LEN;
    localparam int BURST_BOUND  = 40;   // cycles allowed per vector entry
    localparam int SETUP_CYCLES = 100;  // reset and init gating phase

    logic clk = 1'b0;
    logic rst;
    logic hdmi_vsync, hdmi_href, init_done;
    logic buf_wr_en;
    mosaic_pkg::data_t buf_wr_data;
    logic axi_arvalid, axi_arready;
    mosaic_pkg::addr_t axi_araddr;
    logic [3:0] axi_arlen;
    logic [2:0] axi_arsize;
    logic [1:0] axi_arburst;
    logic axi_rready, axi_rvalid, axi_rlast;
    mosaic_pkg::data_t axi_rdata;

    logic [31:0] vectors [0:255];
    int vec_count = 0;
    int wr_count = 0;
    int addr_errors = 0;
    int data_errors = 0;
    int ctrl_errors = 0;
    mosaic_pkg::addr_t ar_q [$];    // accepted AR addresses in order
    mosaic_pkg::data_t beat_q [$];  // R beats not yet seen on the buffer port
    mosaic_pkg::data_t exp_data;
    string cur_test = "reset_state";

    mosaic_line_reader mosaic_line_reader_i (.*);

    always #10 clk = ~clk;

    task automatic finish_report();
        $display("errors: address %0d, data %0d, control %0d",
                 addr_errors, data_errors, ctrl_errors);
        if (addr_errors + data_errors + ctrl_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // sampled mid-cycle, away from the stimulus edge
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (axi_arvalid || axi_rready || buf_wr_en) begin
                $display("ERROR: %s, AXI or buffer activity while the reader should be idle",
                         cur_test);
                ctrl_errors++;
            end
        end
    endtask

    task automatic start_line(input logic use_vsync);
        @(posedge clk);
        #2;
        if (use_vsync) begin
            hdmi_vsync = 1'b1;  // rise clears tile offsets
            repeat (3) begin
                @(posedge clk);
                #2;
            end
            hdmi_vsync = 1'b0;  // fall opens the first line
        end else begin
            hdmi_href = 1'b1;
            @(posedge clk);
            #2;
            hdmi_href = 1'b0;
        end
    endtask

    // AXI read slave with random arready delay and random gaps between beats
    initial begin : axi_slave
        int delay;
        int gap;
        mosaic_pkg::addr_t held_addr;
        void'($urandom(32'hfa90_d303));
        axi_arready = 1'b0;
        axi_rvalid  = 1'b0;
        axi_rlast   = 1'b0;
        axi_rdata   = '0;
        forever begin
            @(posedge clk);
            #2;
            if (axi_arvalid) begin
                held_addr = axi_araddr;
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                    if (!axi_arvalid) begin
                        $display("ERROR: arvalid dropped before arready was given");
                        ctrl_errors++;
                    end else if (axi_araddr !== held_addr) begin
                        $display("CHECK FAILED ar_backpressure: expected %h, actual %h",
                                 held_addr, axi_araddr);
                        ctrl_errors++;
                    end
                end
                axi_arready = 1'b1;
                ar_q.push_back(axi_araddr);
                @(posedge clk);
                #2;
                axi_arready = 1'b0;
                if (axi_arvalid || !axi_rready) begin
                    $display("ERROR: arvalid still high or rready low after the AR transfer");
                    ctrl_errors++;
                end
                for (int beat = 0; beat < `MR_BURST_LEN; beat++) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                    axi_rdata  = {$urandom, $urandom};
                    axi_rlast  = (beat == `MR_BURST_LEN - 1);
                    axi_rvalid = 1'b1;
                    beat_q.push_back(axi_rdata);
                    @(posedge clk);
                    #2;
                    axi_rvalid = 1'b0;
                    axi_rlast  = 1'b0;
                end
            end
        end
    end

    // each buffer write carries the oldest beat still queued
    always @(negedge clk) begin
        if (buf_wr_en) begin
            wr_count++;
            if (beat_q.size() == 0) begin
                $display("ERROR: buffer write with no R beat pending");
                data_errors++;
            end else begin
                exp_data = beat_q.pop_front();
                if (buf_wr_data !== exp_data) begin
                    $display("CHECK FAILED data_passthrough: expected %h, actual %h",
                             exp_data, buf_wr_data);
                    data_errors++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (vec_count > 0);
        repeat (SETUP_CYCLES + vec_count * BURST_BOUND) @(posedge clk);
        $display("ERROR: watchdog expired before the vectors were done");
        ctrl_errors++;
        finish_report();
    end

    initial begin : main
        int idx;
        int line_no;
        int target;
        logic seen_vsync;
        mosaic_pkg::addr_t got;
        mosaic_pkg::addr_t exp;
        rst        = 1'b0;
        hdmi_vsync = 1'b0;
        hdmi_href  = 1'b0;
        init_done  = 1'b0;
        seen_vsync = 1'b0;
        line_no    = 0;
        $readmemh("verification/mosaic_vectors.hex", vectors);
        for (idx = 0; idx < 256 && vec_count == 0; idx++) begin
            if (vectors[idx] === END_MARK) begin
                vec_count = idx + 1;
            end
        end
        if (vec_count == 0) begin
            $display("ERROR: no end marker found in the vector file");
            ctrl_errors++;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        check_idle(2);
        if ({axi_arlen, axi_arsize, axi_arburst} !== {4'd3, 3'd3, 2'b01}) begin
            $display("CHECK FAILED ar_fields: expected %h, actual %h",
                     {4'd3, 3'd3, 2'b01}, {axi_arlen, axi_arsize, axi_arburst});
            ctrl_errors++;
        end
        cur_test = "init_gating";
        start_line(1'b0);  // href falls while init_done is low
        check_idle(12);
        @(posedge clk);
        #2;
        init_done = 1'b1;
        check_idle(4);
        cur_test = "tile_order";
        idx = 0;
        while (vec_count != 0 && vectors[idx] !== END_MARK) begin
            if (vectors[idx] !== HREF_MARK && vectors[idx] !== VSYNC_MARK) begin
                $display("ERROR: unknown marker %h at vector entry %0d", vectors[idx], idx);
                ctrl_errors++;
                break;
            end
            line_no++;
            if (seen_vsync || vectors[idx] === VSYNC_MARK) begin
                seen_vsync = 1'b1;
                cur_test = "vsync_reset";
            end else if (line_no > 6) begin
                cur_test = "frame_bank";  // second bank from frame count 2
            end
            target = wr_count + LINE_WRITES;
            start_line(vectors[idx] === VSYNC_MARK);
            idx++;
            while (wr_count < target) begin
                @(posedge clk);
            end
            if (ar_q.size() != LINE_BURSTS) begin
                $display("ERROR: %s line %0d gave %0d AR transfers instead of %0d",
                         cur_test, line_no, ar_q.size(), LINE_BURSTS);
                addr_errors++;
            end
            for (int k = 0; k < LINE_BURSTS; k++) begin
                exp = vectors[idx][`MR_ADDR_W-1:0];
                idx++;
                if (ar_q.size() != 0) begin
                    got = ar_q.pop_front();
                    if (got !== exp) begin
                        $display("CHECK FAILED %s line %0d burst %0d: expected %h, actual %h",
                                 cur_test, line_no, k, exp, got);
                        addr_errors++;
                    end
                end
            end
            check_idle(10);  // nothing more until the next sync edge
            if (ar_q.size() != 0 || wr_count != target) begin
                $display("ERROR: %s line %0d, extra AR transfers or buffer writes",
                         cur_test, line_no);
                ctrl_errors++;
                ar_q.delete();
            end
        end
        finish_report();
    end

endmodule

// File: mosaic_line_reader.f
+incdir+verilog
verilog/mosaic_pkg.sv
verilog/burst_cmd_if.sv
verilog/line_trigger.sv
verilog/tile_sequencer.sv
verilog/tile_address_gen.sv
verilog/axi_burst_reader.sv
verilog/mosaic_line_reader.sv
verification/mosaic_line_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the mosaic line reader testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mosaic_line_reader_tb \
    -f mosaic_line_reader.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vmosaic_line_reader_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation PASSED"

// File: verification/mosaic_vectors.hex
// one line read per text line: marker, then the 8 expected araddr values for tiles 0 to 3
// markers: f0000001 pulse href, f0000002 pulse vsync, f00000ff end of vectors
f0000001 0000 0020 0800 0820 1000 1020 1800 1820
f0000001 0040 0060 0840 0860 1040 1060 1840 1860
f0000001 0080 00a0 0880 08a0 1080 10a0 1880 18a0
f0000001 0000 0020 0800 0820 1000 1020 1800 1820
f0000001 0040 0060 0840 0860 1040 1060 1840 1860
f0000001 0080 00a0 0880 08a0 1080 10a0 1880 18a0
f0000001 0400 0420 0c00 0c20 1400 1420 1c00 1c20
f0000001 0440 0460 0c40 0c60 1440 1460 1c40 1c60
f0000001 0480 04a0 0c80 0ca0 1480 14a0 1c80 1ca0
f0000001 0400 0420 0c00 0c20 1400 1420 1c00 1c20
f0000002 0400 0420 0c00 0c20 1400 1420 1c00 1c20
f0000001 0440 0460 0c40 0c60 1440 1460 1c40 1c60
f0000001 0480 04a0 0c80 0ca0 1480 14a0 1c80 1ca0
f0000001 0000 0020 0800 0820 1000 1020 1800 1820
f00000ff
